// File: manycore_io.f
+incdir+common
common/io_link_pkg.sv
common/mem_pkg.sv
src/io_fifo.sv
src/pod_startup.sv
src/test_mem.sv
io_row/io_router_node.sv
io_row/io_row.sv
src/manycore_io_top.sv
test/tb_clock_gen.sv
test/manycore_io_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the I/O edge testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

if ! verilator --binary --timing --assert --top-module manycore_io_tb -f manycore_io.f; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/Vmanycore_io_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx "NO ERRORS" "$LOG"; then
  exit 0
fi
echo "pass line missing from $LOG"
exit 1

// File: test/manycore_io_tb.sv
// ##############################
// testbench for the I/O edge: startup, per-column loads and
// stores, out-of-range rejection and host back-pressure
// ##############################

`include "io_defs.svh"

module manycore_io_tb
  import io_link_pkg::*;
;

  localparam int WAIT_LIMIT = 2000;
  localparam int NUM_TAGS = 1 << `IO_TAG_W;

  logic     clk, arst_n_i, host_req_v_i, host_req_ready_o;
  logic     host_resp_v_o, host_resp_ready_i, tag_done_o;
  io_req_s  host_req_i;
  io_resp_s host_resp_o;

  // reference model by tag and by column/address
  logic [`IO_DATA_W-1:0] model_mem [`IO_NUM_X][`MEM_WORDS];
  logic                  model_written [`IO_NUM_X][`MEM_WORDS];
  io_resp_op_e           exp_op [NUM_TAGS];
  logic [`IO_DATA_W-1:0] exp_data [NUM_TAGS];
  logic                  outstanding [NUM_TAGS];
  int                    resp_seq [NUM_TAGS];
  int                    pending_cnt, resp_cnt, seed_val;
  logic                  mon_en, bp_mode, hold_pending;
  io_resp_s              held_resp;

  tb_clock_gen #(.PERIOD(8)) clkgen (.clk_o(clk));

  manycore_io_top dut0 (
    .clk_i(clk), .arst_n_i(arst_n_i),
    .host_req_v_i(host_req_v_i), .host_req_i(host_req_i),
    .host_req_ready_o(host_req_ready_o),
    .host_resp_v_o(host_resp_v_o), .host_resp_o(host_resp_o),
    .host_resp_ready_i(host_resp_ready_i), .tag_done_o(tag_done_o)
  );

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("ERRORS FOUND");
    $fatal(1, "stopped at first failing check");
  endtask

  task automatic accept_req(input io_req_s q);
    outstanding[q.tag] = 1'b1;
    pending_cnt++;
    if (q.x >= `IO_X_W'(`IO_NUM_X)) begin
      exp_op[q.tag] = e_resp_error;
    end else if (q.op == e_io_store) begin
      exp_op[q.tag] = e_resp_store_ack;
      model_mem[q.x][q.addr] = q.data;
      model_written[q.x][q.addr] = 1'b1;
    end else begin
      exp_op[q.tag] = e_resp_load_data;
      exp_data[q.tag] = model_mem[q.x][q.addr];
    end
  endtask

  task automatic retire_resp(input io_resp_s r);
    assert (outstanding[r.tag]) else
      report_failure($sformatf("response with tag %0h arrived with no request in flight", r.tag));
    assert (r.op == exp_op[r.tag]) else
      report_failure($sformatf("[ERROR] host_resp_o.op expected %h got %h (tag %h)",
                               exp_op[r.tag], r.op, r.tag));
    if (exp_op[r.tag] == e_resp_load_data) begin
      assert (r.data == exp_data[r.tag]) else
        report_failure($sformatf("[ERROR] host_resp_o.data expected %h got %h (tag %h)",
                                 exp_data[r.tag], r.data, r.tag));
    end
    outstanding[r.tag] = 1'b0;
    pending_cnt--;
    resp_seq[r.tag] = resp_cnt;
    resp_cnt++;
  endtask

  // sampled at negedge so a handshake seen here completes at the next rising edge
  always @(negedge clk) begin
    if (mon_en) begin
      if (hold_pending) begin
        assert (host_resp_v_o) else
          report_failure($sformatf("[ERROR] host_resp_v_o expected 1 got %h before transfer",
                                   host_resp_v_o));
        assert (host_resp_o == held_resp) else
          report_failure($sformatf("[ERROR] host_resp_o expected %h got %h",
                                   held_resp, host_resp_o));
      end
      hold_pending = host_resp_v_o && !host_resp_ready_i;
      held_resp = host_resp_o;
      if (host_resp_v_o && host_resp_ready_i) retire_resp(host_resp_o);
      if (host_req_v_i && host_req_ready_o) accept_req(host_req_i);
    end
  end

  always @(posedge clk) begin
    #1;
    host_resp_ready_i = bp_mode ? 1'($urandom_range(0, 1)) : 1'b1;
  end

  task automatic pick_free_tag(output int tag);
    int waited;
    int start;
    tag = -1;
    waited = 0;
    while (tag < 0) begin
      start = int'($urandom % NUM_TAGS);
      for (int i = 0; i < NUM_TAGS; i++) begin
        if (tag < 0 && !outstanding[(start + i) % NUM_TAGS]) tag = (start + i) % NUM_TAGS;
      end
      if (tag < 0) begin
        waited++;
        if (waited > WAIT_LIMIT) report_failure("timed out waiting for a free request tag");
        @(posedge clk);
        #1;
      end
    end
  endtask

  task automatic send_req(input io_op_e op, input logic [`IO_X_W-1:0] x,
                          input logic [`IO_ADDR_W-1:0] addr,
                          input logic [`IO_DATA_W-1:0] data, output int tag);
    int waited;
    pick_free_tag(tag);
    host_req_i.op = op;
    host_req_i.x = x;
    host_req_i.addr = addr;
    host_req_i.data = data;
    host_req_i.tag = `IO_TAG_W'(tag);
    host_req_v_i = 1'b1;
    waited = 0;
    @(negedge clk);
    while (!host_req_ready_o) begin
      waited++;
      if (waited > WAIT_LIMIT) report_failure("timed out waiting for host_req_ready_o");
      @(negedge clk);
    end
    @(posedge clk);
    #1;
    host_req_v_i = 1'b0;
  endtask

  task automatic wait_drain();
    int waited;
    waited = 0;
    @(negedge clk);
    while (pending_cnt != 0) begin
      waited++;
      if (waited > WAIT_LIMIT) report_failure("timed out waiting for outstanding responses");
      @(negedge clk);
    end
    @(posedge clk);
    #1;
  endtask

  initial begin
    int waited;
    int st_tag;
    int ld_tag;
    int tag;
    logic [`IO_X_W-1:0]    rx;
    logic [`IO_ADDR_W-1:0] raddr;
    io_op_e                rop;
    seed_val = int'($urandom(32'h10f6_1a22));
    arst_n_i = 1'b1;
    host_req_v_i = 1'b0;
    host_req_i = '0;
    host_resp_ready_i = 1'b0;
    mon_en = 1'b0;
    bp_mode = 1'b0;
    hold_pending = 1'b0;
    held_resp = '0;
    pending_cnt = 0;
    resp_cnt = 0;
    for (int t = 0; t < NUM_TAGS; t++) outstanding[t] = 1'b0;
    for (int c = 0; c < `IO_NUM_X; c++) begin
      for (int a = 0; a < `MEM_WORDS; a++) model_written[c][a] = 1'b0;
    end
    #1 arst_n_i = 1'b0;
    repeat (4) @(posedge clk);
    #1 arst_n_i = 1'b1;

    // startup check k follows the k-th edge after release
    for (int k = 1; k <= `TAG_PROGRAM_CYCLES + `RESET_DEPTH; k++) begin
      @(posedge clk);
      @(negedge clk);
      assert (tag_done_o == (k >= `TAG_PROGRAM_CYCLES)) else
        report_failure($sformatf("[ERROR] tag_done_o expected %h got %h at cycle %0d",
                                 k >= `TAG_PROGRAM_CYCLES, tag_done_o, k));
      assert (!host_req_ready_o) else
        report_failure($sformatf("[ERROR] host_req_ready_o expected 0 got %h at cycle %0d",
                                 host_req_ready_o, k));
      assert (!host_resp_v_o) else
        report_failure($sformatf("[ERROR] host_resp_v_o expected 0 got %h at cycle %0d",
                                 host_resp_v_o, k));
    end
    waited = 0;
    while (!host_req_ready_o) begin
      waited++;
      if (waited > WAIT_LIMIT) report_failure("host_req_ready_o never rose after startup");
      @(negedge clk);
    end
    mon_en = 1'b1;
    @(posedge clk);
    #1;

    // store then load in a single column
    send_req(e_io_store, 3'd1, 8'h21, $urandom, st_tag);
    send_req(e_io_load, 3'd1, 8'h21, '0, ld_tag);
    wait_drain();
    assert (resp_seq[ld_tag] > resp_seq[st_tag]) else
      report_failure("load data returned before the store acknowledge");

    // every column at one address with requests overlapping
    for (int c = 0; c < `IO_NUM_X; c++) begin
      send_req(e_io_store, `IO_X_W'(c), 8'h5a, ($urandom & 32'hffff_fff0) | 32'(c), tag);
    end
    for (int c = 0; c < `IO_NUM_X; c++) send_req(e_io_load, `IO_X_W'(c), 8'h5a, '0, tag);
    wait_drain();

    // out of range requests and then a readback of every column
    for (int c = 0; c < `IO_NUM_X; c++) send_req(e_io_store, `IO_X_W'(c), 8'h33, $urandom, tag);
    wait_drain();
    for (int c = `IO_NUM_X; c < (1 << `IO_X_W); c++) begin
      send_req(e_io_store, `IO_X_W'(c), 8'h33, $urandom, tag);
      send_req(e_io_load, `IO_X_W'(c), 8'h33, '0, tag);
    end
    wait_drain();
    for (int c = 0; c < `IO_NUM_X; c++) send_req(e_io_load, `IO_X_W'(c), 8'h33, '0, tag);
    wait_drain();

    // random mix under host back-pressure
    bp_mode = 1'b1;
    for (int n = 0; n < 80; n++) begin
      rx = `IO_X_W'($urandom % (1 << `IO_X_W));
      raddr = 8'h40 + `IO_ADDR_W'($urandom % 4);
      if (rx < `IO_X_W'(`IO_NUM_X) && !model_written[rx][raddr]) rop = e_io_store;
      else rop = ($urandom % 2) ? e_io_store : e_io_load;
      send_req(rop, rx, raddr, $urandom, tag);
    end
    wait_drain();
    bp_mode = 1'b0;
    repeat (4) @(posedge clk);

    $display("NO ERRORS");
    $finish;
  end

endmodule

// File: test/tb_clock_gen.sv
// ##############################
// free-running clock for the I/O edge testbench
// ##############################

module tb_clock_gen #(
  parameter int PERIOD = 8
) (
  output logic clk_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD / 2) clk_o = ~clk_o;
  end

endmodule

// File: src/manycore_io_top.sv
// ##############################
// I/O edge top: startup sequencing, router row and
// one test memory under each column
// ##############################

`include "io_defs.svh"

module manycore_io_top
  import io_link_pkg::*;
  import mem_pkg::*;
(
  input  logic     clk_i,
  input  logic     arst_n_i,
  input  logic     host_req_v_i,
  input  io_req_s  host_req_i,
  output logic     host_req_ready_o,
  output logic     host_resp_v_o,
  output io_resp_s host_resp_o,
  input  logic     host_resp_ready_i,
  output logic     tag_done_o
);

  logic                     core_reset;
  logic [`IO_NUM_X-1:0]     mem_req_v, mem_req_ready;
  mem_req_s [`IO_NUM_X-1:0] mem_req;
  logic [`IO_NUM_X-1:0]     mem_resp_v, mem_resp_yumi;
  io_resp_s [`IO_NUM_X-1:0] mem_resp;

  pod_startup startup (
    .clk_i(clk_i), .arst_n_i(arst_n_i),
    .tag_done_o(tag_done_o), .core_reset_o(core_reset)
  );

  io_row row (
    .clk_i(clk_i), .reset_i(core_reset),
    .host_req_v_i(host_req_v_i), .host_req_i(host_req_i),
    .host_req_ready_o(host_req_ready_o),
    .host_resp_v_o(host_resp_v_o), .host_resp_o(host_resp_o),
    .host_resp_ready_i(host_resp_ready_i),
    .mem_req_v_o(mem_req_v), .mem_req_o(mem_req), .mem_req_ready_i(mem_req_ready),
    .mem_resp_v_i(mem_resp_v), .mem_resp_i(mem_resp), .mem_resp_yumi_o(mem_resp_yumi)
  );

  for (genvar x = 0; x < `IO_NUM_X; x++) begin : mem_x
    test_mem mem (
      .clk_i(clk_i), .reset_i(core_reset),
      .req_v_i(mem_req_v[x]), .req_i(mem_req[x]), .req_ready_o(mem_req_ready[x]),
      .resp_v_o(mem_resp_v[x]), .resp_o(mem_resp[x]), .resp_yumi_i(mem_resp_yumi[x])
    );
  end

endmodule

// File: io_row/io_row.sv
// ##############################
// host-attached row of I/O routers, one per column
// rejects requests past the east end with an error response
// ##############################

`include "io_defs.svh"

module io_row
  import io_link_pkg::*;
  import mem_pkg::*;
(
  input  logic                    clk_i,
  input  logic                    reset_i,
  input  logic                    host_req_v_i,
  input  io_req_s                 host_req_i,
  output logic                    host_req_ready_o,
  output logic                    host_resp_v_o,
  output io_resp_s                host_resp_o,
  input  logic                    host_resp_ready_i,
  output logic [`IO_NUM_X-1:0]    mem_req_v_o,
  output mem_req_s [`IO_NUM_X-1:0] mem_req_o,
  input  logic [`IO_NUM_X-1:0]    mem_req_ready_i,
  input  logic [`IO_NUM_X-1:0]    mem_resp_v_i,
  input  io_resp_s [`IO_NUM_X-1:0] mem_resp_i,
  output logic [`IO_NUM_X-1:0]    mem_resp_yumi_o
);

  // link state at each column boundary, index b sits west of node b
  logic [`IO_NUM_X:0]     req_v_b, req_ready_b, resp_v_b, resp_ready_b;
  io_req_s [`IO_NUM_X:0]  req_b;
  io_resp_s [`IO_NUM_X:0] resp_b;

  logic     in_v, in_ready, in_oob;
  io_req_s  in_req;
  logic     err_v;
  io_resp_s err_resp;
  logic     eg_v, eg_ready;
  io_resp_s eg_resp;

  io_fifo #(.payload_t(io_req_s)) ingress (
    .clk_i(clk_i), .reset_i(reset_i),
    .v_i(host_req_v_i), .data_i(host_req_i), .ready_o(host_req_ready_o),
    .v_o(in_v), .data_o(in_req), .ready_i(in_ready)
  );

  assign in_oob = (in_req.x >= `IO_X_W'(`IO_NUM_X));

  // out-of-range head turns into an error and never enters the chain
  assign err_v         = in_v & in_oob;
  assign err_resp.op   = e_resp_error;
  assign err_resp.data = '0;
  assign err_resp.tag  = in_req.tag;

  assign req_v_b[0] = in_v & ~in_oob;
  assign req_b[0]   = in_req;
  assign in_ready   = in_oob ? eg_ready : req_ready_b[0];

  // error has priority, it is blocking the ingress head
  assign eg_v            = err_v | resp_v_b[0];
  assign eg_resp         = err_v ? err_resp : resp_b[0];
  assign resp_ready_b[0] = eg_ready & ~err_v;

  io_fifo #(.payload_t(io_resp_s)) egress (
    .clk_i(clk_i), .reset_i(reset_i),
    .v_i(eg_v), .data_i(eg_resp), .ready_o(eg_ready),
    .v_o(host_resp_v_o), .data_o(host_resp_o), .ready_i(host_resp_ready_i)
  );

  for (genvar x = 0; x < `IO_NUM_X; x++) begin : rtr_x
    io_router_node #(.my_x_p(x)) node (
      .clk_i(clk_i), .reset_i(reset_i),
      .req_v_i(req_v_b[x]), .req_i(req_b[x]), .req_ready_o(req_ready_b[x]),
      .req_v_o(req_v_b[x+1]), .req_o(req_b[x+1]), .req_ready_i(req_ready_b[x+1]),
      .resp_v_i(resp_v_b[x+1]), .resp_i(resp_b[x+1]), .resp_ready_o(resp_ready_b[x+1]),
      .resp_v_o(resp_v_b[x]), .resp_o(resp_b[x]), .resp_ready_i(resp_ready_b[x]),
      .mem_req_v_o(mem_req_v_o[x]), .mem_req_o(mem_req_o[x]),
      .mem_req_ready_i(mem_req_ready_i[x]),
      .mem_resp_v_i(mem_resp_v_i[x]), .mem_resp_i(mem_resp_i[x]),
      .mem_resp_yumi_o(mem_resp_yumi_o[x])
    );
  end

  // nothing lives east of the last column
  assign req_ready_b[`IO_NUM_X] = 1'b0;
  assign resp_v_b[`IO_NUM_X]    = 1'b0;
  assign resp_b[`IO_NUM_X]      = '0;

  a_no_east_escape: assert property (
    @(posedge clk_i) disable iff (reset_i) !req_v_b[`IO_NUM_X]
  ) else $error("request left the east end of the row, x=%0h", req_b[`IO_NUM_X].x);

endmodule

// File: io_row/io_router_node.sv
// ##############################
// one column of the I/O row: buffers requests from the west,
// delivers local ones south and forwards the rest east
// ##############################

`include "io_defs.svh"

module io_router_node
  import io_link_pkg::*;
  import mem_pkg::*;
#(
  parameter int unsigned my_x_p = 0
) (
  input  logic     clk_i,
  input  logic     reset_i,
  // requests, west in and east out
  input  logic     req_v_i,
  input  io_req_s  req_i,
  output logic     req_ready_o,
  output logic     req_v_o,
  output io_req_s  req_o,
  input  logic     req_ready_i,
  // responses, east in and west out
  input  logic     resp_v_i,
  input  io_resp_s resp_i,
  output logic     resp_ready_o,
  output logic     resp_v_o,
  output io_resp_s resp_o,
  input  logic     resp_ready_i,
  // local test memory
  output logic     mem_req_v_o,
  output mem_req_s mem_req_o,
  input  logic     mem_req_ready_i,
  input  logic     mem_resp_v_i,
  input  io_resp_s mem_resp_i,
  output logic     mem_resp_yumi_o
);

  localparam logic [`IO_X_W-1:0] MY_X = `IO_X_W'(my_x_p);

  logic     rq_v, rq_ready, rq_local;
  io_req_s  rq;
  logic     rf_v, rf_ready;
  io_resp_s rf_resp;
  logic     grant_local, grant_east;
  logic     east_first_r;

  io_fifo #(.payload_t(io_req_s)) req_fifo (
    .clk_i(clk_i), .reset_i(reset_i),
    .v_i(req_v_i), .data_i(req_i), .ready_o(req_ready_o),
    .v_o(rq_v), .data_o(rq), .ready_i(rq_ready)
  );

  // X routing
  assign rq_local = (rq.x == MY_X);
  assign rq_ready = rq_local ? mem_req_ready_i : req_ready_i;

  assign mem_req_v_o = rq_v & rq_local;
  assign req_v_o     = rq_v & ~rq_local;
  assign req_o       = rq;

  always_comb begin
    mem_req_o.write = (rq.op == e_io_store);
    mem_req_o.addr  = rq.addr;
    mem_req_o.data  = rq.data;
    mem_req_o.tag   = rq.tag;
  end

  // round-robin between the local memory and the east neighbour
  assign grant_local = mem_resp_v_i & (~resp_v_i | ~east_first_r);
  assign grant_east  = resp_v_i & ~grant_local;

  assign rf_v    = mem_resp_v_i | resp_v_i;
  assign rf_resp = grant_local ? mem_resp_i : resp_i;

  assign mem_resp_yumi_o = grant_local & rf_ready;
  assign resp_ready_o    = grant_east & rf_ready;

  always_ff @(posedge clk_i or posedge reset_i) begin
    if (reset_i) begin
      east_first_r <= 1'b0;
    end else if (rf_v & rf_ready) begin
      // whoever just won yields next time
      east_first_r <= grant_local;
    end
  end

  io_fifo #(.payload_t(io_resp_s)) resp_fifo (
    .clk_i(clk_i), .reset_i(reset_i),
    .v_i(rf_v), .data_i(rf_resp), .ready_o(rf_ready),
    .v_o(resp_v_o), .data_o(resp_o), .ready_i(resp_ready_i)
  );

endmodule

// File: src/test_mem.sv
// ##############################
// word memory standing in below one column
// one request at a time, response held until yumi
// ##############################

`include "io_defs.svh"

module test_mem
  import io_link_pkg::*;
  import mem_pkg::*;
(
  input  logic     clk_i,
  input  logic     reset_i,
  input  logic     req_v_i,
  input  mem_req_s req_i,
  output logic     req_ready_o,
  output logic     resp_v_o,
  output io_resp_s resp_o,
  input  logic     resp_yumi_i
);

  logic [`IO_DATA_W-1:0] mem_r [`MEM_WORDS];
  logic                  resp_v_r;
  io_resp_s              resp_r;
  logic                  accept;

  assign req_ready_o = ~resp_v_r;
  assign accept      = req_v_i & req_ready_o;

  always_ff @(posedge clk_i or posedge reset_i) begin
    if (reset_i) begin
      resp_v_r <= 1'b0;
    end else if (accept) begin
      resp_v_r <= 1'b1;
    end else if (resp_yumi_i) begin
      resp_v_r <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      if (req_i.write) begin
        mem_r[req_i.addr] <= req_i.data;
        resp_r.op         <= e_resp_store_ack;
        resp_r.data       <= '0;
      end else begin
        resp_r.op   <= e_resp_load_data;
        resp_r.data <= mem_r[req_i.addr];
      end
      resp_r.tag <= req_i.tag;
    end
  end

  assign resp_v_o = resp_v_r;
  assign resp_o   = resp_r;

  a_resp_hold: assert property (
    @(posedge clk_i) disable iff (reset_i)
      (resp_v_o && !resp_yumi_i) |=> (resp_v_o && $stable(resp_o))
  ) else $error("test_mem response changed before yumi, resp_o=%0h", resp_o);

endmodule

// File: src/pod_startup.sv
// ##############################
// models tag programming after power-on reset, then
// releases the core reset through a short flop chain
// ##############################

`include "io_defs.svh"

module pod_startup (
  input  logic clk_i,
  input  logic arst_n_i,
  output logic tag_done_o,
  output logic core_reset_o
);

  localparam int CNT_W = $clog2(`TAG_PROGRAM_CYCLES);

  logic [CNT_W-1:0]        prog_cnt_r;
  logic                    tag_done_r;
  logic [`RESET_DEPTH-1:0] reset_chain_r;

  // stops counting once programming is done
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      prog_cnt_r <= '0;
      tag_done_r <= 1'b0;
    end else if (!tag_done_r) begin
      if (prog_cnt_r == CNT_W'(`TAG_PROGRAM_CYCLES - 1)) begin
        tag_done_r <= 1'b1;
      end else begin
        prog_cnt_r <= prog_cnt_r + 1'b1;
      end
    end
  end

  // core reset held while tags are still being written
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      reset_chain_r <= '1;
    end else begin
      reset_chain_r <= {reset_chain_r[`RESET_DEPTH-2:0], ~tag_done_r};
    end
  end

  assign tag_done_o   = tag_done_r;
  assign core_reset_o = reset_chain_r[`RESET_DEPTH-1];

  a_tag_done_sticky: assert property (
    @(posedge clk_i) disable iff (!arst_n_i) tag_done_o |=> tag_done_o
  ) else $error("tag_done_o fell after tag programming completed");

endmodule

// File: src/io_fifo.sv
// ##############################
// small ready/valid link buffer, payload given by type
// output is registered, so it adds one cycle per stage
// ##############################

`include "io_defs.svh"

module io_fifo #(
  parameter type payload_t = logic
) (
  input  logic     clk_i,
  input  logic     reset_i,
  input  logic     v_i,
  input  payload_t data_i,
  output logic     ready_o,
  output logic     v_o,
  output payload_t data_o,
  input  logic     ready_i
);

  localparam int DEPTH = `IO_FIFO_DEPTH;
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  payload_t         mem_r [DEPTH];
  logic [PTR_W-1:0] wr_ptr_r;
  logic [PTR_W-1:0] rd_ptr_r;
  logic [CNT_W-1:0] count_r;
  logic [CNT_W-1:0] count_n;
  logic             space_r;
  logic             enq;
  logic             deq;

  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
    return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  assign enq     = v_i & ready_o;
  assign deq     = v_o & ready_i;
  assign count_n = count_r + CNT_W'(enq) - CNT_W'(deq);

  // space is registered so ready stays low through reset
  always_ff @(posedge clk_i or posedge reset_i) begin
    if (reset_i) begin
      wr_ptr_r <= '0;
      rd_ptr_r <= '0;
      count_r  <= '0;
      space_r  <= 1'b0;
    end else begin
      if (enq) wr_ptr_r <= ptr_inc(wr_ptr_r);
      if (deq) rd_ptr_r <= ptr_inc(rd_ptr_r);
      count_r <= count_n;
      space_r <= (count_n < CNT_W'(DEPTH));
    end
  end

  always_ff @(posedge clk_i) begin
    if (enq) mem_r[wr_ptr_r] <= data_i;
  end

  assign ready_o = space_r;
  assign v_o     = (count_r != '0);
  assign data_o  = mem_r[rd_ptr_r];

  a_no_overflow: assert property (
    @(posedge clk_i) disable iff (reset_i) enq |-> (count_r < CNT_W'(DEPTH))
  ) else $error("io_fifo written while full");

  // equal pointers with a read are only legal when every slot is filled
  a_no_underflow: assert property (
    @(posedge clk_i) disable iff (reset_i)
      deq |-> ((rd_ptr_r != wr_ptr_r) || (count_r == CNT_W'(DEPTH)))
  ) else $error("io_fifo read while empty");

endmodule

// File: common/mem_pkg.sv
// ##############################
// request format between a router node and its test memory
// ##############################

`include "io_defs.svh"

package mem_pkg;

  typedef logic [`IO_ADDR_W-1:0] mem_addr_t;

  // column field already stripped, tag kept for the response
  typedef struct packed {
    logic                   write;
    mem_addr_t              addr;
    logic [`IO_DATA_W-1:0]  data;
    logic [`IO_TAG_W-1:0]   tag;
  } mem_req_s;

endpackage

// File: common/io_link_pkg.sv
// ##############################
// packet types carried along the I/O router row
// requests travel east, responses travel west
// ##############################

`include "io_defs.svh"

package io_link_pkg;

  typedef enum logic {
    e_io_load  = 1'b0,
    e_io_store = 1'b1
  } io_op_e;

  // error marks a request addressed past the east end
  typedef enum logic [1:0] {
    e_resp_load_data = 2'd0,
    e_resp_store_ack = 2'd1,
    e_resp_error     = 2'd2
  } io_resp_op_e;

  typedef struct packed {
    io_op_e                 op;
    logic [`IO_X_W-1:0]     x;
    logic [`IO_ADDR_W-1:0]  addr;
    logic [`IO_DATA_W-1:0]  data;
    logic [`IO_TAG_W-1:0]   tag;
  } io_req_s;

  typedef struct packed {
    io_resp_op_e            op;
    logic [`IO_DATA_W-1:0]  data;
    logic [`IO_TAG_W-1:0]   tag;
  } io_resp_s;

endpackage

// File: common/io_defs.svh
// ##############################
// sizes and timing constants for the I/O edge
// include wherever a width, depth or cycle count is needed
// ##############################

`ifndef IO_DEFS_SVH
`define IO_DEFS_SVH

// row geometry, x field covers columns past the east end
`define IO_NUM_X 4
`define IO_X_W 3

`define IO_ADDR_W 8
`define IO_DATA_W 32
`define IO_TAG_W 4

// words behind each column
`define MEM_WORDS 256

// startup sequencing
`define TAG_PROGRAM_CYCLES 16
`define RESET_DEPTH 3

`define IO_FIFO_DEPTH 2

`endif
